/* logic/corr_pkg.sv */
package corr_pkg;

   // ------------------------------
   // Array geometry
   // ------------------------------
   localparam int NANT     = 6;                     // One bit per antenna per sample
   localparam int NBASE    = NANT * (NANT - 1) / 2; // 15 baselines
   localparam int BLK_BASE = 8;                     // Baselines per visibility block

   // Antenna pair of each baseline, slot 15 is the empty one in block 1
   localparam int BASE_A [16] = '{0, 0, 0, 0, 0, 1, 1, 1, 1, 2, 2, 2, 3, 3, 4, 0};
   localparam int BASE_B [16] = '{1, 2, 3, 4, 5, 2, 3, 4, 5, 3, 4, 5, 4, 5, 5, 0};

   // ------------------------------
   // Bus geometry
   // ------------------------------
   localparam int BUS_W = 16;  // Data width
   localparam int ADR_W = 6;   // Word address width

   // Unit field adr[5:4]
   localparam logic [1:0] UNIT_BLK0 = 2'd0;  // Baselines 0..7
   localparam logic [1:0] UNIT_BLK1 = 2'd1;  // Baselines 8..14
   localparam logic [1:0] UNIT_SYS  = 2'd2;  // System registers
   // Code 3 is left unmapped and answers with err

   // Register select adr[0] inside the system unit
   localparam logic REG_BLOCKSIZE = 1'b0;  // Pairs per period minus one
   localparam logic REG_BANKS     = 1'b1;  // Read-only bank counter

   // Power-up integration period of 128 pairs
   localparam logic [BUS_W-1:0] BLOCKSIZE_RST = 16'd127;

endpackage

/* logic/sample_framer.sv */
`timescale 1ns/1ps

module sample_framer (
   input  logic                       clk_i,
   input  logic                       sw_d,         // Async reset
   input  logic                       enable_i,     // Acquisition active
   input  logic [corr_pkg::NANT-1:0]  antenna_i,    // One bit per antenna
   input  logic [corr_pkg::BUS_W-1:0] blocksize_i,  // Period length minus one
   output logic [corr_pkg::NANT-1:0]  re_o,
   output logic [corr_pkg::NANT-1:0]  im_o,
   output logic                       valid_o,      // re_o/im_o hold a pair
   output logic                       swap_o        // Final pair of the period
);

   logic                       phase;  // Low waits for re, high waits for im
   logic [corr_pkg::BUS_W-1:0] pairs;  // Pairs taken so far this period
   logic                       last;   // Current pair closes the period

   // Greater-equal also closes a period cut short by a new blocksize
   assign last = (pairs >= blocksize_i);

   // ------------------------------
   // Phase, pair count and strobes
   // ------------------------------
   always_ff @(posedge clk_i or posedge sw_d) begin
      if (sw_d) begin
         phase   <= 1'b0;
         pairs   <= '0;
         valid_o <= 1'b0;
         swap_o  <= 1'b0;
      end else if (!enable_i) begin
         phase   <= 1'b0;   // Restart pairing at re, count holds
         valid_o <= 1'b0;
         swap_o  <= 1'b0;
      end else begin
         phase   <= ~phase;
         valid_o <= phase;            // Pair complete on the im sample
         swap_o  <= phase & last;     // Rides with the last valid
         if (phase) begin
            pairs <= last ? '0 : pairs + 1'b1;
         end
      end
   end

   // Sample holding registers
   always_ff @(posedge clk_i) begin
      if (enable_i) begin
         if (!phase) begin
            re_o <= antenna_i;  // Held until the pair is used
         end else begin
            im_o <= antenna_i;  // Crude quadrature part
         end
      end
   end

endmodule

/* logic/vis_block.sv */
`timescale 1ns/1ps

module vis_block #(
   parameter int ACCUM = 16,  // Accumulator width, at most BUS_W
   parameter int FIRST = 0    // Global index of slot 0
) (
   input  logic                       clk_i,
   input  logic                       sw_d,       // Async reset
   input  logic [corr_pkg::NANT-1:0]  re_i,
   input  logic [corr_pkg::NANT-1:0]  im_i,
   input  logic                       valid_i,    // Pair present this cycle
   input  logic                       swap_i,     // Last pair of the period
   input  logic [3:0]                 rd_adr_i,   // {slot, re/im}
   output logic [corr_pkg::BUS_W-1:0] rd_dat_o
);

   // Readable bank, one word each for re and im per slot
   logic [ACCUM-1:0] bank_re [corr_pkg::BLK_BASE];
   logic [ACCUM-1:0] bank_im [corr_pkg::BLK_BASE];

   logic [2:0]       slot;    // Baseline within this block
   logic             use_im;  // Imaginary word wanted
   logic [ACCUM-1:0] word;    // Selected bank word

   // ------------------------------
   // One correlator per slot
   // ------------------------------
   for (genvar b = 0; b < corr_pkg::BLK_BASE; b++) begin : g_slot
      localparam int IDX = FIRST + b;  // Global baseline number

      if (IDX < corr_pkg::NBASE) begin : g_used
         localparam int ANT_A = corr_pkg::BASE_A[IDX];
         localparam int ANT_B = corr_pkg::BASE_B[IDX];

         logic             hit_re;   // Real parts agree
         logic             hit_im;   // Real of A agrees with quadrature of B
         logic [ACCUM-1:0] acc_re;
         logic [ACCUM-1:0] acc_im;
         logic [ACCUM-1:0] sum_re;   // Count including this pair
         logic [ACCUM-1:0] sum_im;
         logic [ACCUM-1:0] hold_re;  // Bank copy of the finished period
         logic [ACCUM-1:0] hold_im;

         // One-bit correlation is an XNOR
         assign hit_re = ~(re_i[ANT_A] ^ re_i[ANT_B]);
         assign hit_im = ~(re_i[ANT_A] ^ im_i[ANT_B]);

         assign sum_re = acc_re + ACCUM'(hit_re);
         assign sum_im = acc_im + ACCUM'(hit_im);

         always_ff @(posedge clk_i or posedge sw_d) begin
            if (sw_d) begin
               acc_re  <= '0;
               acc_im  <= '0;
               hold_re <= '0;
               hold_im <= '0;
            end else if (valid_i) begin
               if (swap_i) begin
                  // Bank gets the period total, last pair included
                  hold_re <= sum_re;
                  hold_im <= sum_im;
                  acc_re  <= '0;
                  acc_im  <= '0;
               end else begin
                  acc_re  <= sum_re;
                  acc_im  <= sum_im;
               end
            end
         end

         assign bank_re[b] = hold_re;
         assign bank_im[b] = hold_im;

      end else begin : g_empty
         // No baseline here, reads as zero
         assign bank_re[b] = '0;
         assign bank_im[b] = '0;
      end
   end

   // ------------------------------
   // Readout
   // ------------------------------
   assign slot   = rd_adr_i[3:1];
   assign use_im = rd_adr_i[0];

   assign word = use_im ? bank_im[slot] : bank_re[slot];

   // Zero-extend to the bus width
   always_comb begin
      rd_dat_o              = '0;
      rd_dat_o[ACCUM-1:0]   = word;
   end

endmodule

/* logic/vis_bus_regs.sv */
`timescale 1ns/1ps

module vis_bus_regs (
   input  logic                       clk_i,
   input  logic                       sw_d,         // Async reset
   // Wishbone classic slave
   input  logic                       cyc_i,
   input  logic                       stb_i,
   input  logic                       we_i,
   input  logic [corr_pkg::ADR_W-1:0] adr_i,
   input  logic [corr_pkg::BUS_W-1:0] dat_i,
   output logic                       ack_o,
   output logic                       err_o,
   output logic [corr_pkg::BUS_W-1:0] dat_o,
   // Correlator side
   input  logic                       swap_i,       // Bank swap edge
   input  logic [corr_pkg::BUS_W-1:0] blk0_dat_i,
   input  logic [corr_pkg::BUS_W-1:0] blk1_dat_i,
   output logic [3:0]                 rd_adr_o,     // {baseline, re/im}
   output logic [corr_pkg::BUS_W-1:0] blocksize_o,
   output logic                       switch_o      // New bank readable
);

   logic                       req;      // New cycle, no response pending
   logic [3:0]                 sel;      // One-hot unit select
   logic                       bad;      // Unmapped or read-only target
   logic [corr_pkg::BUS_W-1:0] sys_dat;  // System register read word
   logic [corr_pkg::BUS_W-1:0] dat_w;    // Muxed read word
   logic [corr_pkg::BUS_W-1:0] banks;    // Swap counter, wraps

   assign req      = cyc_i & stb_i & ~ack_o & ~err_o;
   assign rd_adr_o = adr_i[3:0];

   // ------------------------------
   // Unit decode and data mux
   // ------------------------------
   always_comb begin
      case (adr_i[5:4])
         corr_pkg::UNIT_BLK0: sel = 4'b0001;
         corr_pkg::UNIT_BLK1: sel = 4'b0010;
         corr_pkg::UNIT_SYS:  sel = 4'b0100;
         default:             sel = 4'b1000;  // Unmapped
      endcase
   end

   // Visibility blocks are read-only
   assign bad = sel[3] | (we_i & (sel[0] | sel[1]));

   assign sys_dat = (adr_i[0] == corr_pkg::REG_BANKS) ? banks : blocksize_o;

   assign dat_w = ({corr_pkg::BUS_W{sel[0]}} & blk0_dat_i)
                | ({corr_pkg::BUS_W{sel[1]}} & blk1_dat_i)
                | ({corr_pkg::BUS_W{sel[2]}} & sys_dat);

   // ------------------------------
   // Response and registers
   // ------------------------------
   always_ff @(posedge clk_i or posedge sw_d) begin
      if (sw_d) begin
         ack_o       <= 1'b0;
         err_o       <= 1'b0;
         blocksize_o <= corr_pkg::BLOCKSIZE_RST;
         banks       <= '0;
         switch_o    <= 1'b0;
      end else begin
         ack_o    <= req & ~bad;  // One wait state
         err_o    <= req & bad;
         switch_o <= swap_i;      // Pulse after the swap edge
         if (swap_i) begin
            banks <= banks + 1'b1;
         end
         // Writes to REG_BANKS get an ack and no effect
         if (req && we_i && sel[2] && adr_i[0] == corr_pkg::REG_BLOCKSIZE) begin
            blocksize_o <= dat_i;
         end
      end
   end

   // Read data, valid with ack_o
   always_ff @(posedge clk_i) begin
      if (req && !we_i && !bad) begin
         dat_o <= dat_w;
      end
   end

endmodule

/* logic/corr_top.sv */
`timescale 1ns/1ps

module corr_top #(
   parameter int ACCUM = 16  // Visibility counter width, at most BUS_W
) (
   input  logic                       clk_i,
   input  logic                       sw_d,       // Async reset, active high

   // Antenna samples
   input  logic                       enable_i,   // Acquisition active
   input  logic [corr_pkg::NANT-1:0]  antenna_i,  // One bit per antenna

   // Wishbone classic slave
   input  logic                       cyc_i,
   input  logic                       stb_i,
   input  logic                       we_i,
   input  logic [corr_pkg::ADR_W-1:0] adr_i,      // {unit, baseline, re/im}
   input  logic [corr_pkg::BUS_W-1:0] dat_i,
   output logic [corr_pkg::BUS_W-1:0] dat_o,
   output logic                       ack_o,
   output logic                       err_o,

   output logic                       switch_o    // Fresh bank readable
);

   // ------------------------------
   // Internal nets
   // ------------------------------
   logic [corr_pkg::NANT-1:0]  re;         // Paired real parts
   logic [corr_pkg::NANT-1:0]  im;         // Paired quadrature parts
   logic                       valid;      // Pair strobe
   logic                       swap;       // Last pair of the period
   logic [corr_pkg::BUS_W-1:0] blocksize;  // From the system unit
   logic [3:0]                 rd_adr;     // Bank word select
   logic [corr_pkg::BUS_W-1:0] blk0_dat;   // Baselines 0..7
   logic [corr_pkg::BUS_W-1:0] blk1_dat;   // Baselines 8..14

   // Sample pairing and period control
   sample_framer framer_inst (
      .clk_i       (clk_i),
      .sw_d        (sw_d),
      .enable_i    (enable_i),
      .antenna_i   (antenna_i),
      .blocksize_i (blocksize),
      .re_o        (re),
      .im_o        (im),
      .valid_o     (valid),
      .swap_o      (swap)
   );

   // ------------------------------
   // Correlator blocks
   // ------------------------------
   vis_block #(
      .ACCUM (ACCUM),
      .FIRST (0)
   ) blk0_inst (
      .clk_i    (clk_i),
      .sw_d     (sw_d),
      .re_i     (re),
      .im_i     (im),
      .valid_i  (valid),
      .swap_i   (swap),
      .rd_adr_i (rd_adr),
      .rd_dat_o (blk0_dat)
   );

   // Slot 7 here has no baseline
   vis_block #(
      .ACCUM (ACCUM),
      .FIRST (corr_pkg::BLK_BASE)
   ) blk1_inst (
      .clk_i    (clk_i),
      .sw_d     (sw_d),
      .re_i     (re),
      .im_i     (im),
      .valid_i  (valid),
      .swap_i   (swap),
      .rd_adr_i (rd_adr),
      .rd_dat_o (blk1_dat)
   );

   // Bus slave, system registers and switch pulse
   vis_bus_regs bus_inst (
      .clk_i       (clk_i),
      .sw_d        (sw_d),
      .cyc_i       (cyc_i),
      .stb_i       (stb_i),
      .we_i        (we_i),
      .adr_i       (adr_i),
      .dat_i       (dat_i),
      .ack_o       (ack_o),
      .err_o       (err_o),
      .dat_o       (dat_o),
      .swap_i      (swap),
      .blk0_dat_i  (blk0_dat),
      .blk1_dat_i  (blk1_dat),
      .rd_adr_o    (rd_adr),
      .blocksize_o (blocksize),
      .switch_o    (switch_o)
   );

endmodule

/* bench/corr_checker.sv */
`timescale 1ns/1ps

module corr_checker #(
   parameter int ACCUM = 16  // Visibility counter width of the DUT
) (
   input  logic                       clk_i,
   input  logic                       sw_d,
   input  logic                       enable_i,
   input  logic [corr_pkg::NANT-1:0]  antenna_i,
   input  logic                       cyc_i,
   input  logic                       stb_i,
   input  logic                       we_i,
   input  logic [corr_pkg::ADR_W-1:0] adr_i,
   input  logic [corr_pkg::BUS_W-1:0] wr_dat_i,  // Master write data
   input  logic [corr_pkg::BUS_W-1:0] rd_dat_i,  // Slave read data
   input  logic                       ack_i,
   input  logic                       err_i,
   input  logic                       switch_i,
   output int                         err_cnt_o,
   output int                         chk_cnt_o
);

   logic                       phase;          // High while a re sample is held
   logic [corr_pkg::NANT-1:0]  held_re;
   logic [corr_pkg::NANT-1:0]  cur_re [$];     // Pairs of the running period
   logic [corr_pkg::NANT-1:0]  cur_im [$];
   logic [corr_pkg::NANT-1:0]  fin_re [$];     // Pairs of the finished period
   logic [corr_pkg::NANT-1:0]  fin_im [$];
   logic [corr_pkg::BUS_W-1:0] exp_vis [32];   // Indexed by adr[4:0]
   logic [corr_pkg::BUS_W-1:0] exp_blocksize;
   logic [corr_pkg::BUS_W-1:0] exp_banks;
   logic                       pending;        // Response due next cycle
   logic                       p_we;
   logic [corr_pkg::ADR_W-1:0] p_adr;
   logic [corr_pkg::BUS_W-1:0] p_dat;

   // Agreement count of one baseline over the finished period
   function automatic logic [corr_pkg::BUS_W-1:0] ref_vis(input int idx, input bit use_im);
      int                         a;
      int                         b;
      int                         n;
      logic [corr_pkg::BUS_W-1:0] r;
      n = 0;
      r = '0;
      if (idx < corr_pkg::NBASE) begin
         a = corr_pkg::BASE_A[idx];
         b = corr_pkg::BASE_B[idx];
         for (int k = 0; k < fin_re.size(); k++) begin
            if (use_im) n += (fin_re[k][a] == fin_im[k][b]);  // re of A against im of B
            else        n += (fin_re[k][a] == fin_re[k][b]);
         end
         r = n % (1 << ACCUM);  // Counter wraps at ACCUM bits
      end
      return r;
   endfunction

   function automatic logic [corr_pkg::BUS_W-1:0] expected_word(input logic [5:0] adr);
      case (adr[5:4])
         corr_pkg::UNIT_BLK0,
         corr_pkg::UNIT_BLK1: return exp_vis[adr[4:0]];
         corr_pkg::UNIT_SYS:  return (adr[0] == corr_pkg::REG_BANKS) ? exp_banks : exp_blocksize;
         default:             return '0;
      endcase
   endfunction

   // ------------------------------
   // Bus response check
   // ------------------------------
   task automatic check_response();
      logic                       bad;
      logic [corr_pkg::BUS_W-1:0] want;
      bad = (p_adr[5:4] == 2'd3)
          || (p_we && (p_adr[5:4] == corr_pkg::UNIT_BLK0 || p_adr[5:4] == corr_pkg::UNIT_BLK1));
      if (!ack_i && !err_i) begin
         $display("Slave gave no response one cycle after the request to 0x%02h", p_adr);
         err_cnt_o++;
      end else if (ack_i && err_i) begin
         $display("Slave raised ack and err together for 0x%02h", p_adr);
         err_cnt_o++;
      end else if (err_i != bad) begin
         $display("Error %0t ns: 0x%02h answered err=%0b, expected %0b", $time, p_adr, err_i, bad);
         err_cnt_o++;
      end else if (ack_i && !p_we) begin
         want = expected_word(p_adr);
         chk_cnt_o++;
         if (rd_dat_i !== want) begin
            $display("Error %0t ns: read 0x%02h gave %0d, expected %0d",
                     $time, p_adr, rd_dat_i, want);
            err_cnt_o++;
         end
      end
      if (ack_i && p_we && p_adr[5:4] == corr_pkg::UNIT_SYS
          && p_adr[0] == corr_pkg::REG_BLOCKSIZE) begin
         exp_blocksize = p_dat;  // Period length for later checks
      end
      pending = 1'b0;
   endtask

   // Freeze the model of the period just closed by a bank swap
   task automatic close_period();
      chk_cnt_o++;
      if (cur_re.size() != int'(exp_blocksize) + 1) begin
         $display("Error %0t ns: period closed after %0d pairs, expected %0d",
                  $time, cur_re.size(), int'(exp_blocksize) + 1);
         err_cnt_o++;
      end
      fin_re = cur_re;
      fin_im = cur_im;
      cur_re.delete();
      cur_im.delete();
      for (int i = 0; i < 16; i++) begin
         exp_vis[2*i]     = ref_vis(i, 1'b0);
         exp_vis[2*i + 1] = ref_vis(i, 1'b1);
      end
      exp_banks++;
   endtask

   // Pairing of enabled samples into {re, im}
   task automatic take_sample();
      if (!enable_i) begin
         phase = 1'b0;                 // Pairing restarts at re
      end else if (!phase) begin
         held_re = antenna_i;
         phase   = 1'b1;
      end else begin
         cur_re.push_back(held_re);
         cur_im.push_back(antenna_i);  // Current sample is the im part
         phase = 1'b0;
      end
   endtask

   always @(posedge clk_i) begin
      if (sw_d) begin
         phase         = 1'b0;
         pending       = 1'b0;
         exp_blocksize = 16'd127;  // Power-up period of 128 pairs
         exp_banks     = '0;
         err_cnt_o     = 0;
         chk_cnt_o     = 0;
         cur_re.delete();
         cur_im.delete();
         foreach (exp_vis[i]) exp_vis[i] = '0;
      end else begin
         // A response reflects the banks before its request edge so it goes first
         if (pending) check_response();
         else if (ack_i || err_i) begin
            $display("Slave responded with no request pending");
            err_cnt_o++;
         end
         if (switch_i) close_period();
         if (cyc_i && stb_i && !ack_i && !err_i) begin
            pending = 1'b1;
            p_we    = we_i;
            p_adr   = adr_i;
            p_dat   = wr_dat_i;
         end
         take_sample();
      end
   end

endmodule

/* bench/corr_tb.sv */
`timescale 1ns/1ps

module corr_tb;

   localparam int          ACCUM   = 16;
   localparam int          PERIODS = 6;                          // Bank swaps to check
   localparam int          TIMEOUT = PERIODS * 2 * 100 + 1000;   // Cycles
   localparam logic [31:0] SEED    = 32'he6d7_8c09;

   // System unit addresses
   localparam logic [5:0] ADR_SIZE  = {corr_pkg::UNIT_SYS, 3'b000, corr_pkg::REG_BLOCKSIZE};
   localparam logic [5:0] ADR_BANKS = {corr_pkg::UNIT_SYS, 3'b000, corr_pkg::REG_BANKS};

   logic                       clk_i;
   logic                       sw_d;
   logic                       enable_i;
   logic [corr_pkg::NANT-1:0]  antenna_i;
   logic                       cyc_i;
   logic                       stb_i;
   logic                       we_i;
   logic [corr_pkg::ADR_W-1:0] adr_i;
   logic [corr_pkg::BUS_W-1:0] dat_i;
   logic [corr_pkg::BUS_W-1:0] dat_o;
   logic                       ack_o;
   logic                       err_o;
   logic                       switch_o;

   int          cycles     = 0;
   int          bench_errs = 0;
   int          chk_errs;
   int          chk_cnt;
   logic [31:0] lfsr;

   corr_top #(.ACCUM(ACCUM)) corr_top_inst (
      .clk_i(clk_i), .sw_d(sw_d), .enable_i(enable_i), .antenna_i(antenna_i),
      .cyc_i(cyc_i), .stb_i(stb_i), .we_i(we_i), .adr_i(adr_i), .dat_i(dat_i),
      .dat_o(dat_o), .ack_o(ack_o), .err_o(err_o), .switch_o(switch_o)
   );

   corr_checker #(.ACCUM(ACCUM)) corr_checker (
      .clk_i(clk_i), .sw_d(sw_d), .enable_i(enable_i), .antenna_i(antenna_i),
      .cyc_i(cyc_i), .stb_i(stb_i), .we_i(we_i), .adr_i(adr_i), .wr_dat_i(dat_i),
      .rd_dat_i(dat_o), .ack_i(ack_o), .err_i(err_o), .switch_i(switch_o),
      .err_cnt_o(chk_errs), .chk_cnt_o(chk_cnt)
   );

   // x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   // ------------------------------
   // Bus master
   // ------------------------------
   task automatic bus_cycle(input logic wr, input logic [5:0] adr, input logic [15:0] wdat,
                            output logic got_err);
      int waited;
      waited = 0;
      cyc_i  = 1'b1;
      stb_i  = 1'b1;
      we_i   = wr;
      adr_i  = adr;
      dat_i  = wdat;
      do begin
         @(posedge clk_i);
         #2;
         waited++;
      end while (!ack_o && !err_o && waited < 8);
      if (!ack_o && !err_o) begin
         $display("No bus response from address 0x%02h within %0d cycles", adr, waited);
         bench_errs++;
      end
      got_err = err_o;
      cyc_i   = 1'b0;  // Classic cycle ends with the response
      stb_i   = 1'b0;
      we_i    = 1'b0;
   endtask

   // One transfer with the response kind it should get
   task automatic access(input logic wr, input logic [5:0] adr, input logic [15:0] wdat,
                         input logic want_err);
      logic got_err;
      bus_cycle(wr, adr, wdat, got_err);
      if (got_err !== want_err) begin
         $display("Error %0t ns: %s of 0x%02h answered with %s", $time,
                  wr ? "write" : "read", adr, got_err ? "err" : "ack");
         bench_errs++;
      end
   endtask

   task automatic read_banks();
      for (int a = 0; a < 32; a++) begin
         access(1'b0, 6'(a), '0, 1'b0);  // Units 0 and 1, empty slot included
      end
   endtask

   task automatic wait_switch();
      do begin
         @(posedge clk_i);
         #2;
      end while (!switch_o);
   endtask

   task automatic drop_enable(input int n);
      enable_i = 1'b0;
      repeat (n) begin
         @(posedge clk_i);
         #2;
      end
      enable_i = 1'b1;
   endtask

   // Error accesses, then the targets read back unchanged
   task automatic probe_errors();
      access(1'b0, 6'h30, '0, 1'b1);      // Unit 3 unmapped
      access(1'b1, 6'h3b, 16'h1234, 1'b1);
      access(1'b1, 6'h00, 16'hffff, 1'b1); // Banks are read-only
      access(1'b1, 6'h1d, 16'hffff, 1'b1);
      access(1'b0, 6'h00, '0, 1'b0);
      access(1'b0, 6'h1d, '0, 1'b0);
   endtask

   // ------------------------------
   // Clock, stimulus and timeout
   // ------------------------------
   initial begin
      clk_i = 1'b0;
      forever #10 clk_i = ~clk_i;
   end

   initial begin
      lfsr      = SEED;
      antenna_i = '0;
      forever begin
         @(posedge clk_i);
         #2;
         for (int b = 0; b < corr_pkg::NANT; b++) begin
            lfsr         = lfsr_next(lfsr);  // One step per antenna bit
            antenna_i[b] = lfsr[0];
         end
      end
   end

   initial begin
      while (cycles < TIMEOUT) begin
         @(posedge clk_i);
         cycles++;
      end
      $display("Run did not finish within %0d cycles", TIMEOUT);
      $display("test failed");
      $finish;
   end

   // ------------------------------
   // Test sequence
   // ------------------------------
   initial begin
      sw_d     = 1'b1;
      enable_i = 1'b0;
      cyc_i    = 1'b0;
      stb_i    = 1'b0;
      we_i     = 1'b0;
      adr_i    = '0;
      dat_i    = '0;
      repeat (16) @(posedge clk_i);
      #2;
      sw_d = 1'b0;
      @(posedge clk_i);
      #2;

      access(1'b0, ADR_SIZE, '0, 1'b0);     // Reset value 127
      access(1'b0, ADR_BANKS, '0, 1'b0);    // No swaps yet
      access(1'b1, ADR_SIZE, 16'd99, 1'b0); // 100 pairs per period
      access(1'b0, ADR_SIZE, '0, 1'b0);
      access(1'b1, ADR_BANKS, 16'h5a5a, 1'b0);  // Acked, no effect
      access(1'b0, ADR_BANKS, '0, 1'b0);
      probe_errors();

      enable_i = 1'b1;
      for (int p = 1; p <= PERIODS; p++) begin
         wait_switch();
         read_banks();
         access(1'b0, ADR_BANKS, '0, 1'b0);
         if (p == 2) begin
            drop_enable(5);
            @(posedge clk_i);  // Single enabled cycle holds a re sample
            #2;
            drop_enable(3);    // Dropped with the pair half taken
         end
         if (p == 4) probe_errors();
      end
      enable_i = 1'b0;
      @(posedge clk_i);
      #2;

      $display("Checks %0d, checker errors %0d, bench errors %0d, cycles %0d",
               chk_cnt, chk_errs, bench_errs, cycles);
      if (chk_errs == 0 && bench_errs == 0 && chk_cnt > 0) begin
         $display("test passed");
      end else begin
         $display("test failed");
      end
      $finish;
   end

endmodule

/* src.f */
logic/corr_pkg.sv
logic/sample_framer.sv
logic/vis_block.sv
logic/vis_bus_regs.sv
logic/corr_top.sv
bench/corr_checker.sv
bench/corr_tb.sv
